//--- Makefile
TOOL       = verilator
TOP        = tb_tinker
RTL_TOP    = tinker_core
FILELIST   = sources.f
FLAGS      = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "simulation gave no result"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/tinker_pkg.sv
`default_nettype none

package tinker_pkg;

    typedef logic [63:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [31:0] addr_t;     // byte address
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] lit_t;      // literal L

    localparam int    REG_COUNT   = 32;
    localparam int    MEM_BYTES   = 16384;               // 16 KB, code and data
    localparam int    MEM_AW      = $clog2(MEM_BYTES);
    localparam int    INSTR_BYTES = 4;
    localparam int    WORD_BYTES  = 8;                   // load/store width
    localparam addr_t PC_RESET    = 32'h2000;

    // kept tinker opcodes, anything else decodes as a no-op
    typedef enum logic [4:0] {
        op_and     = 5'h00,
        op_or      = 5'h01,
        op_xor     = 5'h02,
        op_not     = 5'h03,
        op_shftr   = 5'h04,
        op_shftri  = 5'h05,
        op_shftl   = 5'h06,
        op_shftli  = 5'h07,
        op_brr     = 5'h0a,   // brr L
        op_brnz    = 5'h0b,
        op_halt    = 5'h0f,
        op_load    = 5'h10,   // mov rd,(rs)(L)
        op_mov_rs  = 5'h11,
        op_mov_lit = 5'h12,
        op_store   = 5'h13,   // mov (rd)(L),rs
        op_add     = 5'h18,
        op_addi    = 5'h19,
        op_sub     = 5'h1a,
        op_subi    = 5'h1b
    } opcode_e;

    typedef enum logic [1:0] {
        from_rf    = 2'd0,
        from_exmem = 2'd1,
        from_memwb = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic reg_write;
        logic mem_read;    // load, also selects mem data at writeback
        logic mem_write;
        logic is_branch;
        logic halt;
        logic valid;       // 0 marks a bubble
    } ctrl_t;

    // field order matches the instruction word, msb first
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        lit_t     lit;
    } decode_t;

    typedef struct packed {
        addr_t  pc;
        instr_t instr;
        logic   valid;
    } ifid_t;

    typedef struct packed {
        ctrl_t    ctrl;
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        lit_t     lit;
        addr_t    pc;
        word_t    rd_val;
        word_t    rs_val;
        word_t    rt_val;
    } idex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_result;   // also the memory address
        word_t    store_data;
        reg_idx_t rd;
    } exmem_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    mem_data;
        word_t    alu_result;
        reg_idx_t rd;
    } memwb_t;

    typedef struct packed {
        logic     we;
        reg_idx_t dest;
        word_t    data;
    } retire_t;

endpackage

`default_nettype wire

//--- core/pipeline_control.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
    input  wire                       clk,
    input  wire                       reset,
    input  wire tinker_pkg::decode_t  id_fields,
    input  wire tinker_pkg::ctrl_t    idex_ctrl,
    input  wire tinker_pkg::reg_idx_t idex_rd,
    input  wire tinker_pkg::ctrl_t    exmem_ctrl,
    input  wire tinker_pkg::reg_idx_t exmem_rd,
    input  wire tinker_pkg::ctrl_t    memwb_ctrl,
    input  wire tinker_pkg::reg_idx_t memwb_rd,
    input  wire                       take_branch,
    output tinker_pkg::ctrl_t         id_ctrl,
    output logic                      hold_fetch,   // pc and if/id
    output logic                      flush_ifid,
    output logic                      bubble_idex,
    output tinker_pkg::fwd_sel_e      fwd_rd,       // registered, used in ex
    output tinker_pkg::fwd_sel_e      fwd_rs,
    output tinker_pkg::fwd_sel_e      fwd_rt
);
    import tinker_pkg::*;

    logic load_use, branch_wait, hazard, halted;

    // looked up in decode, one stage early, so each producer has moved down by one
    function automatic fwd_sel_e pick(input reg_idx_t src);
        if (idex_ctrl.reg_write && idex_rd == src)
            return from_exmem;
        if (exmem_ctrl.reg_write && exmem_rd == src)
            return from_memwb;
        return from_rf;   // writer in mem/wb is caught by the rf bypass
    endfunction

    always_comb begin
        id_ctrl       = '0;
        id_ctrl.valid = 1'b1;
        case (id_fields.opcode)
            op_and, op_or, op_xor, op_not,
            op_shftr, op_shftri, op_shftl, op_shftli,
            op_mov_rs, op_mov_lit,
            op_add, op_addi, op_sub, op_subi: id_ctrl.reg_write = 1'b1;
            op_load: begin
                id_ctrl.reg_write = 1'b1;
                id_ctrl.mem_read  = 1'b1;
            end
            op_store:        id_ctrl.mem_write = 1'b1;
            op_brr, op_brnz: id_ctrl.is_branch = 1'b1;
            op_halt:         id_ctrl.halt      = 1'b1;
            default: ;       // unknown op rides along as a no-op
        endcase
    end

    // load result not ready until mem, any field may be a source
    assign load_use = idex_ctrl.mem_read &&
                      (idex_rd == id_fields.rd || idex_rd == id_fields.rs ||
                       idex_rd == id_fields.rt);
    // brnz reads rs in decode, wait for the producer to reach mem/wb
    assign branch_wait = id_fields.opcode == op_brnz &&
                         ((idex_ctrl.reg_write && idex_rd == id_fields.rs) ||
                          (exmem_ctrl.reg_write && exmem_rd == id_fields.rs));
    assign hazard      = load_use || branch_wait;
    assign hold_fetch  = hazard || halted;   // after halt nothing more issues
    assign bubble_idex = hold_fetch;
    assign flush_ifid  = take_branch && id_ctrl.is_branch && !hold_fetch;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            halted <= 1'b0;
            fwd_rd <= from_rf;
            fwd_rs <= from_rf;
            fwd_rt <= from_rf;
        end else begin
            if (id_ctrl.halt && !hazard)
                halted <= 1'b1;
            fwd_rd <= pick(id_fields.rd);
            fwd_rs <= pick(id_fields.rs);
            fwd_rt <= pick(id_fields.rt);
        end
    end

    // worst case is brnz right behind a load
    assert property (@(posedge clk) disable iff (reset)
        !(hazard && $past(hazard) && $past(hazard, 2)));

endmodule

`default_nettype wire

//--- core/tinker_core.sv
`timescale 1ns/1ps
`default_nettype none

module tinker_core (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     prog_we,     // program load, while reset is high
    input  wire tinker_pkg::addr_t  prog_addr,
    input  wire tinker_pkg::instr_t prog_data,
    output tinker_pkg::retire_t     retire,      // what the rf takes this cycle
    output logic                    hlt
);
    import tinker_pkg::*;

    addr_t    pc, pc_next, target, data_addr;
    instr_t   fetch_instr;
    ifid_t    ifid_d, ifid_q;
    idex_t    idex_d, idex_q;
    exmem_t   exmem_d, exmem_q;
    memwb_t   memwb_d, memwb_q;
    decode_t  id_fields;
    ctrl_t    id_ctrl;
    word_t    rf_rd, rf_rs, rf_rt;
    word_t    ex_rd, ex_rs, ex_rt, alu_result;
    word_t    load_data, wb_data;
    logic     take_branch, hold_fetch, flush_ifid, bubble_idex;
    fwd_sel_e fwd_rd, fwd_rs, fwd_rt;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t rf_val,
                                      input word_t exmem_val, input word_t memwb_val);
        case (sel)
            from_exmem: return exmem_val;   // never a load, load-use stalls
            from_memwb: return memwb_val;
            default:    return rf_val;
        endcase
    endfunction

    // fetch
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= PC_RESET;
        else if (!hold_fetch)
            pc <= pc_next;
    end
    assign pc_next = take_branch ? target : pc + addr_t'(INSTR_BYTES);
    assign ifid_d  = '{pc: pc, instr: fetch_instr, valid: 1'b1};

    stage_reg #(.payload_t(ifid_t)) u_ifid (
        .clk(clk), .reset(reset), .hold(hold_fetch), .clear(flush_ifid),
        .d(ifid_d), .q(ifid_q)
    );

    // decode, rf read and early branch
    assign id_fields = decode_t'(ifid_q.instr);

    pipeline_control u_ctrl (
        .clk(clk), .reset(reset), .id_fields(id_fields),
        .idex_ctrl(idex_q.ctrl), .idex_rd(idex_q.rd),
        .exmem_ctrl(exmem_q.ctrl), .exmem_rd(exmem_q.rd),
        .memwb_ctrl(memwb_q.ctrl), .memwb_rd(memwb_q.rd),
        .take_branch(take_branch), .id_ctrl(id_ctrl),
        .hold_fetch(hold_fetch), .flush_ifid(flush_ifid), .bubble_idex(bubble_idex),
        .fwd_rd(fwd_rd), .fwd_rs(fwd_rs), .fwd_rt(fwd_rt)
    );

    reg_file u_rf (
        .clk(clk), .reset(reset), .we(retire.we), .wr_idx(retire.dest),
        .wr_data(retire.data), .rd_idx(id_fields.rd), .rs_idx(id_fields.rs),
        .rt_idx(id_fields.rt), .rd_val(rf_rd), .rs_val(rf_rs), .rt_val(rf_rt)
    );

    branch_unit u_br (
        .opcode(id_fields.opcode), .pc(ifid_q.pc), .rs_val(rf_rs),
        .lit(id_fields.lit), .take_branch(take_branch), .target(target)
    );

    always_comb begin
        idex_d.ctrl   = ifid_q.valid ? id_ctrl : '0;   // flushed slot does nothing
        idex_d.opcode = id_fields.opcode;
        idex_d.rd     = id_fields.rd;
        idex_d.rs     = id_fields.rs;
        idex_d.rt     = id_fields.rt;
        idex_d.lit    = id_fields.lit;
        idex_d.pc     = ifid_q.pc;
        idex_d.rd_val = rf_rd;
        idex_d.rs_val = rf_rs;
        idex_d.rt_val = rf_rt;
    end

    stage_reg #(.payload_t(idex_t)) u_idex (
        .clk(clk), .reset(reset), .hold(1'b0), .clear(bubble_idex),
        .d(idex_d), .q(idex_q)
    );

    // execute, all three operands forwarded
    always_comb begin
        ex_rd = fwd_mux(fwd_rd, idex_q.rd_val, exmem_q.alu_result, wb_data);
        ex_rs = fwd_mux(fwd_rs, idex_q.rs_val, exmem_q.alu_result, wb_data);
        ex_rt = fwd_mux(fwd_rt, idex_q.rt_val, exmem_q.alu_result, wb_data);
        exmem_d.ctrl       = idex_q.ctrl;
        exmem_d.alu_result = alu_result;
        exmem_d.store_data = ex_rs;   // store writes rs
        exmem_d.rd         = idex_q.rd;
    end

    alu u_alu (
        .opcode(idex_q.opcode), .rd_val(ex_rd), .rs_val(ex_rs), .rt_val(ex_rt),
        .lit(idex_q.lit), .result(alu_result)
    );

    stage_reg #(.payload_t(exmem_t)) u_exmem (
        .clk(clk), .reset(reset), .hold(1'b0), .clear(1'b0),
        .d(exmem_d), .q(exmem_q)
    );

    // memory, address parked at 0 unless the op touches memory
    assign data_addr = (exmem_q.ctrl.mem_read || exmem_q.ctrl.mem_write) ?
                       exmem_q.alu_result[31:0] : '0;

    unified_memory u_mem (
        .clk(clk), .fetch_addr(pc), .fetch_instr(fetch_instr),
        .data_addr(data_addr), .load_data(load_data),
        .store_we(exmem_q.ctrl.mem_write), .store_data(exmem_q.store_data),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data)
    );

    assign memwb_d = '{ctrl: exmem_q.ctrl, mem_data: load_data,
                       alu_result: exmem_q.alu_result, rd: exmem_q.rd};

    stage_reg #(.payload_t(memwb_t)) u_memwb (
        .clk(clk), .reset(reset), .hold(1'b0), .clear(1'b0),
        .d(memwb_d), .q(memwb_q)
    );

    // writeback
    assign wb_data = memwb_q.ctrl.mem_read ? memwb_q.mem_data : memwb_q.alu_result;
    assign retire  = '{we: memwb_q.ctrl.reg_write, dest: memwb_q.rd, data: wb_data};
    assign hlt     = memwb_q.ctrl.halt;

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire tinker_pkg::opcode_e opcode,
    input  wire tinker_pkg::word_t   rd_val,
    input  wire tinker_pkg::word_t   rs_val,
    input  wire tinker_pkg::word_t   rt_val,
    input  wire tinker_pkg::lit_t    lit,
    output tinker_pkg::word_t        result
);
    import tinker_pkg::*;

    word_t lit_z, lit_s;

    assign lit_z = {52'd0, lit};          // addi, subi, shifts
    assign lit_s = {{52{lit[11]}}, lit};  // address offsets

    always_comb begin
        result = '0;
        case (opcode)
            op_add:     result = rs_val + rt_val;
            op_addi:    result = rd_val + lit_z;
            op_sub:     result = rs_val - rt_val;
            op_subi:    result = rd_val - lit_z;
            op_and:     result = rs_val & rt_val;
            op_or:      result = rs_val | rt_val;
            op_xor:     result = rs_val ^ rt_val;
            op_not:     result = ~rs_val;               // rt ignored
            op_shftr:   result = rs_val >> rt_val;      // full rt, 64 or more gives 0
            op_shftri:  result = rd_val >> lit_z;
            op_shftl:   result = rs_val << rt_val;
            op_shftli:  result = rd_val << lit_z;
            op_mov_rs:  result = rs_val;
            op_mov_lit: result = {rd_val[63:12], lit};  // only low 12 bits change
            op_load:    result = rs_val + lit_s;        // address from rs
            op_store:   result = rd_val + lit_s;        // address from rd
            default: ;  // branches, halt, no-ops
        endcase
    end

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  wire tinker_pkg::opcode_e opcode,
    input  wire tinker_pkg::addr_t   pc,       // pc of the branch itself
    input  wire tinker_pkg::word_t   rs_val,
    input  wire tinker_pkg::lit_t    lit,
    output logic                     take_branch,
    output tinker_pkg::addr_t        target
);
    import tinker_pkg::*;

    // both kept branches are pc relative
    assign target = pc + {{20{lit[11]}}, lit};

    always_comb begin
        case (opcode)
            op_brr:  take_branch = 1'b1;
            op_brnz: take_branch = rs_val != '0;   // rs is settled, control stalls otherwise
            default: take_branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       we,
    input  wire tinker_pkg::reg_idx_t wr_idx,
    input  wire tinker_pkg::word_t    wr_data,
    input  wire tinker_pkg::reg_idx_t rd_idx,
    input  wire tinker_pkg::reg_idx_t rs_idx,
    input  wire tinker_pkg::reg_idx_t rt_idx,
    output tinker_pkg::word_t         rd_val,
    output tinker_pkg::word_t         rs_val,
    output tinker_pkg::word_t         rt_val
);
    import tinker_pkg::*;

    word_t regs [REG_COUNT];

    // write-through, decode sees this cycle's writeback
    function automatic word_t read_port(input reg_idx_t idx);
        return (we && wr_idx == idx) ? wr_data : regs[idx];
    endfunction

    always_comb begin
        rd_val = read_port(rd_idx);   // base for store, addi, shift-by-literal
        rs_val = read_port(rs_idx);
        rt_val = read_port(rt_idx);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assert property (@(posedge clk) disable iff (reset) we |-> !$isunknown(wr_data));

endmodule

`default_nettype wire

//--- logic/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      hold,    // stall, keep current contents
    input  wire      clear,   // load a bubble
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            q <= '0;
        else if (clear)
            q <= '0;   // all zero, ctrl.valid drops
        else if (!hold)
            q <= d;
    end

    assert property (@(posedge clk) disable iff (reset) !(hold && clear));

endmodule

`default_nettype wire

//--- logic/unified_memory.sv
`timescale 1ns/1ps
`default_nettype none

module unified_memory (
    input  wire                     clk,
    input  wire tinker_pkg::addr_t  fetch_addr,
    output tinker_pkg::instr_t      fetch_instr,
    input  wire tinker_pkg::addr_t  data_addr,
    output tinker_pkg::word_t       load_data,
    input  wire                     store_we,
    input  wire tinker_pkg::word_t  store_data,
    input  wire                     prog_we,
    input  wire tinker_pkg::addr_t  prog_addr,
    input  wire tinker_pkg::instr_t prog_data
);
    import tinker_pkg::*;

    logic [7:0]        mem [MEM_BYTES];   // little endian bytes
    logic [MEM_AW-1:0] f_base, d_base, p_base;

    assign f_base = fetch_addr[MEM_AW-1:0];
    assign d_base = data_addr[MEM_AW-1:0];
    assign p_base = prog_addr[MEM_AW-1:0];

    // combinational reads
    for (genvar i = 0; i < INSTR_BYTES; i++) begin : g_fetch
        assign fetch_instr[8*i +: 8] = mem[f_base + MEM_AW'(i)];
    end
    for (genvar i = 0; i < WORD_BYTES; i++) begin : g_load
        assign load_data[8*i +: 8] = mem[d_base + MEM_AW'(i)];
    end

    always_ff @(posedge clk) begin
        if (prog_we) begin
            for (int i = 0; i < INSTR_BYTES; i++)
                mem[p_base + MEM_AW'(i)] <= prog_data[8*i +: 8];
        end
        if (store_we) begin
            for (int i = 0; i < WORD_BYTES; i++)
                mem[d_base + MEM_AW'(i)] <= store_data[8*i +: 8];
        end
    end

    // no access wraps past the top of memory
    assert property (@(posedge clk)
        fetch_addr <= addr_t'(MEM_BYTES - INSTR_BYTES) &&
        data_addr <= addr_t'(MEM_BYTES - WORD_BYTES) &&
        (!prog_we || prog_addr <= addr_t'(MEM_BYTES - INSTR_BYTES)));

endmodule

`default_nettype wire

//--- sources.f
+incdir+tb
common/tinker_pkg.sv
logic/stage_reg.sv
logic/reg_file.sv
logic/alu.sv
logic/branch_unit.sv
logic/unified_memory.sv
core/pipeline_control.sv
core/tinker_core.sv
tb/tb_tinker.sv

//--- tb/tinker_model.svh
`ifndef TINKER_MODEL_SVH
`define TINKER_MODEL_SVH

// instruction-level model, every register write lands in exp_q in program order
word_t m_regs [REG_COUNT];
word_t m_store [addr_t];   // stored 8-byte words, keyed by byte address

// data region start contents, mixes every address bit
function automatic instr_t fill_word(input addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
endfunction

function automatic word_t read_data(input addr_t a);
    if (m_store.exists(a))
        return m_store[a];
    return {fill_word(a + 32'd4), fill_word(a)};   // little endian pair
endfunction

task automatic run_model();
    addr_t   pc, next_pc, off;
    decode_t f;
    word_t   rdv, rsv, rtv, res;
    logic    writes, done;
    int      steps;
    retire_t w;
    foreach (m_regs[i])
        m_regs[i] = '0;
    m_store.delete();
    exp_q.delete();
    pc    = PC_RESET;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 4 * MAX_WORDS) begin
        f       = decode_t'(prog[(pc - PC_RESET) / INSTR_BYTES]);
        rdv     = m_regs[f.rd];
        rsv     = m_regs[f.rs];
        rtv     = m_regs[f.rt];
        off     = addr_t'($signed(f.lit));   // branch and address offset
        next_pc = pc + INSTR_BYTES;
        res     = '0;
        writes  = 1'b1;
        case (f.opcode)
            op_and:     res = rsv & rtv;
            op_or:      res = rsv | rtv;
            op_xor:     res = rsv ^ rtv;
            op_not:     res = ~rsv;
            op_shftr:   res = (rtv > 63) ? '0 : rsv >> rtv[5:0];
            op_shftri:  res = (f.lit > 63) ? '0 : rdv >> f.lit[5:0];
            op_shftl:   res = (rtv > 63) ? '0 : rsv << rtv[5:0];
            op_shftli:  res = (f.lit > 63) ? '0 : rdv << f.lit[5:0];
            op_mov_rs:  res = rsv;
            op_mov_lit: res = {rdv[63:12], f.lit};   // upper bits kept
            op_add:     res = rsv + rtv;
            op_addi:    res = rdv + word_t'(f.lit);  // L unsigned
            op_sub:     res = rsv - rtv;
            op_subi:    res = rdv - word_t'(f.lit);
            op_load:    res = read_data(rsv[31:0] + off);
            op_store: begin
                m_store[rdv[31:0] + off] = rsv;
                writes = 1'b0;
            end
            op_brr: begin
                next_pc = pc + off;
                writes  = 1'b0;
            end
            op_brnz: begin
                if (rsv != '0)
                    next_pc = pc + off;
                writes = 1'b0;
            end
            op_halt: begin
                done   = 1'b1;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes) begin
            m_regs[f.rd] = res;
            w = '{we: 1'b1, dest: f.rd, data: res};
            exp_q.push_back(w);
        end
        pc    = next_pc;
        steps = steps + 1;
    end
endtask

`endif

//--- tb/tb_tinker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tinker;
    import tinker_pkg::*;

    localparam int       PROG_LEN     = 60;       // random instructions before halt
    localparam int       MAX_WORDS    = 80;
    localparam int       DATA_WORDS   = 512;      // 32-bit fill words, 0x3000-0x37ff
    localparam addr_t    DATA_BASE    = 32'h3000;
    localparam reg_idx_t BASE_REG     = 5'd30;    // load/store base, written once
    localparam int       RESET_CYCLES = 2;
    localparam int       RUN_TIMEOUT  = 1000;
    localparam int       DRAIN_CYCLES = 8;        // quiet time after halt
    localparam opcode_e  ALU_OPS [14] = '{op_and, op_or, op_xor, op_not, op_shftr,
                                          op_shftri, op_shftl, op_shftli, op_mov_rs,
                                          op_mov_lit, op_add, op_addi, op_sub, op_subi};

    logic    clk, reset, prog_we, hlt;
    addr_t   prog_addr;
    instr_t  prog_data;
    retire_t retire;

    integer   seed;
    instr_t   prog [MAX_WORDS];
    int       prog_len;
    reg_idx_t last_dest;    // newest result, sources lean on it
    retire_t  exp_q [$];    // model writes not yet seen
    int       exp_total;
    int       retired;

    `include "tinker_model.svh"

    tinker_core dut_i (
        .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .retire(retire), .hlt(hlt)
    );

    always #2 clk = ~clk;   // 4 ns period

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic fail_value(input string test, input word_t expected, input word_t actual);
        stop_with_failure($sformatf("error %s: expected %0h, actual %0h",
                                    test, expected, actual));
    endtask

    function automatic int rand_below(input int n);
        return int'(($random(seed) & 32'h7fff_ffff) % n);
    endfunction

    function automatic reg_idx_t pick_dest();
        return (rand_below(2) == 0) ? last_dest : reg_idx_t'(rand_below(30));   // never r30/r31
    endfunction

    function automatic reg_idx_t pick_src();
        return (rand_below(2) == 0) ? last_dest : reg_idx_t'(rand_below(REG_COUNT));
    endfunction

    function automatic lit_t data_offset();
        return lit_t'(8 * rand_below(256) - 1024);   // base 0x3400, 8-aligned
    endfunction

    function automatic instr_t encode(input opcode_e op, input reg_idx_t rd,
                                      input reg_idx_t rs, input reg_idx_t rt, input lit_t lit);
        decode_t f;
        f = '{opcode: op, rd: rd, rs: rs, rt: rt, lit: lit};
        return instr_t'(f);
    endfunction

    task automatic emit(input instr_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic emit_alu(input reg_idx_t src);
        opcode_e  op;
        reg_idx_t dest;
        lit_t     lit;
        op   = ALU_OPS[rand_below(14)];
        dest = pick_dest();
        if (op == op_shftri || op == op_shftli)
            lit = lit_t'(rand_below(72));   // some shifts past 63
        else
            lit = lit_t'(rand_below(4096));
        emit(encode(op, dest, src, pick_src(), lit));
        last_dest = dest;
    endtask

    task automatic build_program();
        int       kind;
        int       skip;
        reg_idx_t d, d2;
        lit_t     off;
        opcode_e  op;
        prog_len = 0;
        emit(encode(op_mov_lit, BASE_REG, 5'd0, 5'd0, 12'h034));
        emit(encode(op_shftli, BASE_REG, 5'd0, 5'd0, 12'd8));   // base now 0x3400
        last_dest = 5'd0;
        while (prog_len < PROG_LEN) begin
            kind = rand_below(10);
            case (kind)
                6: begin   // load then immediate use
                    d  = pick_dest();
                    d2 = pick_dest();
                    emit(encode(op_load, d, BASE_REG, 5'd0, data_offset()));
                    emit(encode(op_add, d2, d, pick_src(), '0));
                    last_dest = d2;
                end
                7: begin   // store then load, same address
                    off = data_offset();
                    d   = pick_dest();
                    emit(encode(op_store, BASE_REG, pick_src(), 5'd0, off));
                    emit(encode(op_load, d, BASE_REG, 5'd0, off));
                    last_dest = d;
                end
                8, 9: begin
                    // forward only, target stays inside the program
                    if (prog_len < PROG_LEN - 5) begin
                        skip = 1 + rand_below(3);
                        op   = (kind == 8) ? op_brr : op_brnz;
                        emit(encode(op, 5'd0, pick_src(), 5'd0,
                                    lit_t'(INSTR_BYTES * (skip + 1))));
                    end
                end
                default: emit_alu(pick_src());
            endcase
        end
        for (int i = 0; i < 4; i++)
            emit(encode(op_halt, '0, '0, '0, '0));   // padding behind the real halt
    endtask

    task automatic write_word(input addr_t a, input instr_t d);
        @(negedge clk);
        prog_we   = 1'b1;
        prog_addr = a;
        prog_data = d;
    endtask

    task automatic load_memory();
        addr_t a;
        for (int i = 0; i < prog_len; i++)
            write_word(PC_RESET + addr_t'(INSTR_BYTES * i), prog[i]);
        for (int i = 0; i < DATA_WORDS; i++) begin
            a = DATA_BASE + addr_t'(4 * i);
            write_word(a, fill_word(a));
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic check_retire();
        retire_t exp;
        assert (exp_q.size() > 0)
            else stop_with_failure("retire.we rose after every expected write was seen");
        exp = exp_q.pop_front();
        assert (retire.dest == exp.dest)
            else fail_value($sformatf("writeback %0d dest", retired),
                            word_t'(exp.dest), word_t'(retire.dest));
        assert (retire.data == exp.data)
            else fail_value($sformatf("writeback %0d data r%0d", retired, exp.dest),
                            exp.data, retire.data);
        retired++;
    endtask

    // mid-cycle sample, one look per retire
    always @(negedge clk) begin
        if (reset) begin
            assert (!retire.we) else stop_with_failure("retire.we rose while reset was high");
        end else if (retire.we) begin
            check_retire();
        end
    end

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (!hlt && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (hlt)
            else stop_with_failure($sformatf("timeout, hlt did not rise in %0d cycles",
                                             RUN_TIMEOUT));
    endtask

    initial begin
        seed      = 32;
        clk       = 1'b0;
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        retired   = 0;
        build_program();
        run_model();
        exp_total = exp_q.size();
        load_memory();   // core held in reset meanwhile
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        wait_for_halt();
        repeat (DRAIN_CYCLES) @(negedge clk);
        assert (retired == exp_total)
            else fail_value("retired write count", word_t'(exp_total), word_t'(retired));
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
